//--- fp_to_int_unit.f
+incdir+verilog
verilog/fp_conv_pkg.sv
verilog/fp_unpack.sv
verilog/mant_shifter.sv
verilog/int_pack.sv
verilog/conv_ctrl.sv
verilog/fp_to_int_unit.sv
verification/clk_gen.sv
verification/fp_to_int_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the float to int testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f fp_to_int_unit.f \
  --top-module fp_to_int_tb \
  -o fp_to_int_sim

output=$(./obj_dir/fp_to_int_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^SIMULATION PASSED$"; then
  exit 0
else
  echo "no passing result found in the simulation output"
  exit 1
fi

//--- verification/fp_to_int_tb.sv
// Directed and seeded random tests for the float to int converter.
// Inputs change on the falling edge; outputs are read there too.
`timescale 1ns/1ps
`include "fp_conv_cfg.svh"

module fp_to_int_tb;

  import fp_conv_pkg::*;

  localparam int unsigned timeout_cycles = 20000;

  logic        clk;
  logic        rst;
  logic        a_stb;
  fp_word_t    a_data;
  logic        a_ack;
  logic        z_stb;
  int_word_t   z_data;
  logic        z_ack;
  int unsigned cycle_count = 0;

  clk_gen i_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  fp_to_int_unit i_fp_to_int_unit (
    .clk    (clk),
    .rst    (rst),
    .a_stb  (a_stb),
    .a_data (a_data),
    .z_ack  (z_ack),
    .a_ack  (a_ack),
    .z_stb  (z_stb),
    .z_data (z_data)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_int(input string name, input int_word_t got, input int_word_t expected);
    if (got !== expected) begin
      abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                          $time, name, got, expected));
    end
  endtask

  task automatic check_ctrl(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                          $time, name, got, expected));
    end
  endtask

  // truncation toward zero, worked out from the raw fields.
  function automatic int_word_t truncate_to_int(input fp_word_t word);
    logic [7:0]  biased;
    int          unbiased;
    logic [63:0] mag;
    int_word_t   mag_lo;
    int_word_t   result;
    biased   = word[30:23];
    unbiased = int'(biased) - `FP_EXP_BIAS;
    mag      = {40'd0, 1'b1, word[22:0]};
    if (biased == 8'd0) begin
      result = '0;
    end else if (unbiased >= 31) begin
      result = `INT_SAT_VALUE; // inf and NaN land here too.
    end else if (unbiased < 0) begin
      result = '0;
    end else begin
      if (unbiased >= `FP_MANT_BITS) begin
        mag = mag << (unbiased - `FP_MANT_BITS);
      end else begin
        mag = mag >> (`FP_MANT_BITS - unbiased);
      end
      mag_lo = mag[31:0];
      result = word[31] ? -mag_lo : mag_lo;
    end
    return result;
  endfunction

  // called on a falling edge; holds z_ack low for hold cycles once z_stb is up.
  task automatic convert(input fp_word_t word, input int_word_t expected,
                         input int unsigned hold);
    int_word_t held;
    a_data = word;
    a_stb  = 1'b1;
    while (!a_ack) @(negedge clk);
    @(negedge clk); // accepted on the edge just passed.
    a_stb = 1'b0;
    check_ctrl("a_ack", a_ack, 1'b0);
    while (!z_stb) begin
      check_ctrl("a_ack", a_ack, 1'b0);
      @(negedge clk);
    end
    held = z_data;
    check_int("z_data", z_data, expected);
    repeat (hold) begin
      @(negedge clk);
      check_ctrl("z_stb", z_stb, 1'b1);
      check_int("z_data", z_data, held);
      check_ctrl("a_ack", a_ack, 1'b0);
    end
    z_ack = 1'b1;
    @(negedge clk);
    z_ack = 1'b0;
    check_ctrl("z_stb", z_stb, 1'b0);
  endtask

  task automatic check_reset_state();
    check_ctrl("a_ack", a_ack, 1'b0);
    check_ctrl("z_stb", z_stb, 1'b0);
    @(negedge clk);
    check_ctrl("a_ack", a_ack, 1'b1);
    check_ctrl("z_stb", z_stb, 1'b0);
  endtask

  task automatic test_exact_values();
    convert(32'h3F80_0000, 32'h0000_0001, 0);  // 1.0
    convert(32'h437F_0000, 32'h0000_00FF, 0);  // 255.0
    convert(32'hBF80_0000, 32'hFFFF_FFFF, 0);  // -1.0
    convert(32'hC780_0000, 32'hFFFF_0000, 1);  // -65536.0
    convert(32'h4E80_0000, 32'h4000_0000, 0);  // 2^30
    convert(32'h4EFF_FFFF, 32'h7FFF_FF80, 0);  // largest below 2^31.
    convert(32'hCEFF_FFFF, 32'h8000_0080, 0);
  endtask

  task automatic test_truncation();
    convert(32'h4030_0000, 32'h0000_0002, 0);  // 2.75
    convert(32'hC030_0000, 32'hFFFF_FFFE, 0);  // -2.75
    convert(32'h3F00_0000, 32'h0000_0000, 0);  // 0.5
    convert(32'h0000_0000, 32'h0000_0000, 0);
    convert(32'h8000_0000, 32'h0000_0000, 0);  // negative zero.
    convert(32'h0000_0001, 32'h0000_0000, 0);  // subnormals.
    convert(32'h807F_FFFF, 32'h0000_0000, 2);
  endtask

  task automatic test_saturation();
    convert(32'h4F00_0000, `INT_SAT_VALUE, 0); // 2^31
    convert(32'hCF00_0000, `INT_SAT_VALUE, 0); // -2^31
    convert(32'h60AD_78EC, `INT_SAT_VALUE, 0); // 1e20
    convert(32'h7F80_0000, `INT_SAT_VALUE, 0);
    convert(32'hFF80_0000, `INT_SAT_VALUE, 0);
    convert(32'h7FC0_0000, `INT_SAT_VALUE, 3); // quiet NaN.
  endtask

  task automatic test_back_pressure();
    fp_word_t words [4];
    int unsigned hold;
    words[0] = 32'h4030_0000;
    words[1] = 32'hC780_0000;
    words[2] = 32'h7F80_0000;
    words[3] = 32'h0000_0000;
    for (int i = 0; i < 12; i++) begin
      hold = $urandom_range(10, 0);
      convert(words[i % 4], truncate_to_int(words[i % 4]), hold);
    end
  endtask

  // biased exponent 122 to 162 spans -5 to 35.
  task automatic test_random_words();
    logic [31:0] r;
    logic [7:0]  biased;
    fp_word_t    word;
    int unsigned hold;
    for (int i = 0; i < 250; i++) begin
      r      = $urandom();
      biased = 8'(122 + $urandom_range(40, 0));
      word   = {r[31], biased, r[22:0]};
      hold   = $urandom_range(10, 0);
      convert(word, truncate_to_int(word), hold);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      abort_run("timeout: the converter stopped responding before the tests ended");
    end
  end

  initial begin
    a_stb  = 1'b0;
    a_data = '0;
    z_ack  = 1'b0;
    void'($urandom(73));
    @(negedge rst);
    check_reset_state();
    test_exact_values();
    test_truncation();
    test_saturation();
    test_back_pressure();
    test_random_words();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verification/clk_gen.sv
// 10 ns clock and active high reset for the testbench.
// Reset covers two rising edges and is released on a falling edge.
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- verilog/fp_to_int_unit.sv
// Float to signed 32 bit integer, truncating toward zero.
// Out of range, inf and NaN give 80000000 hex. One conversion at a time.
`timescale 1ns/1ps

module fp_to_int_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   a_stb,
  input  fp_conv_pkg::fp_word_t  a_data,
  input  logic                   z_ack,
  output logic                   a_ack,
  output logic                   z_stb,
  output fp_conv_pkg::int_word_t z_data
);

  import fp_conv_pkg::*;

  logic        load_operand;
  logic        is_zero;
  logic        is_overflow;
  logic        shift_start;
  logic        shift_done;
  logic        result_load;
  result_sel_t result_sel;
  fp_fields_t  fields;
  mant_t       mant;

  conv_ctrl i_conv_ctrl (
    .clk          (clk),
    .rst          (rst),
    .a_stb        (a_stb),
    .z_ack        (z_ack),
    .is_zero      (is_zero),
    .is_overflow  (is_overflow),
    .shift_done   (shift_done),
    .a_ack        (a_ack),
    .z_stb        (z_stb),
    .load_operand (load_operand),
    .shift_start  (shift_start),
    .result_load  (result_load),
    .result_sel   (result_sel)
  );

  fp_unpack i_fp_unpack (
    .clk          (clk),
    .load_operand (load_operand),
    .a_data       (a_data),
    .fields       (fields),
    .is_zero      (is_zero),
    .is_overflow  (is_overflow)
  );

  mant_shifter i_mant_shifter (
    .clk         (clk),
    .rst         (rst),
    .shift_start (shift_start),
    .fields      (fields),
    .shift_done  (shift_done),
    .mant        (mant)
  );

  int_pack i_int_pack (
    .clk         (clk),
    .rst         (rst),
    .result_load (result_load),
    .result_sel  (result_sel),
    .fields      (fields),
    .mant        (mant),
    .z_data      (z_data)
  );

endmodule

//--- verilog/conv_ctrl.sv
// Control FSM for the converter, one item in flight.
// Both ports transfer on the edge where strobe and ack are high;
// the DUT lowers its own ack or strobe on that edge.
`timescale 1ns/1ps

module conv_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     a_stb,
  input  logic                     z_ack,
  input  logic                     is_zero,
  input  logic                     is_overflow,
  input  logic                     shift_done,
  output logic                     a_ack,
  output logic                     z_stb,
  output logic                     load_operand,
  output logic                     shift_start,
  output logic                     result_load,
  output fp_conv_pkg::result_sel_t result_sel
);

  import fp_conv_pkg::*;

  conv_state_t state;
  result_sel_t sel_q;

  assign load_operand = (state == idle) && a_ack && a_stb;
  assign shift_start  = (state == classify) && !is_zero && !is_overflow;
  assign result_load  = (state == pack);
  assign result_sel   = sel_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      a_ack <= 1'b0;
      z_stb <= 1'b0;
      sel_q <= res_zero;
    end else begin
      case (state)
        idle: begin
          a_ack <= 1'b1;
          if (a_ack && a_stb) begin
            a_ack <= 1'b0;
            state <= classify;
          end
        end

        classify: begin
          if (is_zero) begin
            sel_q <= res_zero;
            state <= pack;
          end else if (is_overflow) begin
            sel_q <= res_sat;
            state <= pack;
          end else begin
            sel_q <= res_shifted; // shifter started this cycle.
            state <= align;
          end
        end

        align: begin
          if (shift_done) begin
            state <= pack;
          end
        end

        pack: begin
          state <= emit;
        end

        emit: begin
          z_stb <= 1'b1;
          if (z_stb && z_ack) begin
            z_stb <= 1'b0;
            state <= idle;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // input and output phases never overlap.
  a_one_phase: assert property (@(posedge clk) disable iff (rst)
    !(a_ack && z_stb));

  // a waiting result keeps its strobe and is not reloaded.
  a_z_hold: assert property (@(posedge clk) disable iff (rst)
    z_stb && !z_ack |=> z_stb && !result_load);

endmodule

//--- verilog/int_pack.sv
// Result register. The aligned mantissa saturates if the hidden
// one is still at the msb, else the sign is applied.
`timescale 1ns/1ps
`include "fp_conv_cfg.svh"

module int_pack (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     result_load,
  input  fp_conv_pkg::result_sel_t result_sel,
  input  fp_conv_pkg::fp_fields_t  fields,
  input  fp_conv_pkg::mant_t       mant,
  output fp_conv_pkg::int_word_t   z_data
);

  import fp_conv_pkg::*;

  int_word_t shifted;
  int_word_t next_z;

  always_comb begin
    if (mant[`INT_WIDTH-1]) begin
      shifted = `INT_SAT_VALUE; // 2^31 and up including -2^31.
    end else if (fields.sign) begin
      shifted = int_word_t'(-mant);
    end else begin
      shifted = int_word_t'(mant);
    end
  end

  always_comb begin
    case (result_sel)
      res_sat:     next_z = `INT_SAT_VALUE;
      res_shifted: next_z = shifted;
      default:     next_z = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      z_data <= '0;
    end else if (result_load) begin
      z_data <= next_z;
    end
  end

endmodule

//--- verilog/mant_shifter.sv
// Aligns the mantissa one bit per cycle toward integer weight.
// Expects an exponent no larger than the stop exponent at start.
`timescale 1ns/1ps
`include "fp_conv_cfg.svh"

module mant_shifter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    shift_start,
  input  fp_conv_pkg::fp_fields_t fields,
  output logic                    shift_done,
  output fp_conv_pkg::mant_t      mant
);

  import fp_conv_pkg::*;

  exp_t  exp_q;
  mant_t mant_q;
  logic  busy;
  logic  finished;

  // stop at integer weight or once every bit has shifted out.
  assign finished = (exp_q >= exp_t'(`SHIFT_STOP_EXP)) || (mant_q == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      shift_done <= 1'b0;
    end else if (shift_start) begin
      busy       <= 1'b1;
      shift_done <= 1'b0;
    end else if (busy && finished) begin
      busy       <= 1'b0;
      shift_done <= 1'b1; // held until next start.
    end
  end

  always_ff @(posedge clk) begin
    if (shift_start) begin
      exp_q  <= fields.exp;
      mant_q <= fields.mant;
    end else if (busy && !finished) begin
      exp_q  <= exp_q + exp_t'(1);
      mant_q <= mant_q >> 1;
    end
  end

  assign mant = mant_q;

  // overflow operands must have been routed to saturation by the controller.
  a_exp_in_range: assert property (@(posedge clk) disable iff (rst)
    busy |-> (exp_q <= exp_t'(`SHIFT_STOP_EXP)));

endmodule

//--- verilog/fp_unpack.sv
// Holds the accepted float and splits it into fields.
// a_data is sampled only on load_operand; classification is combinational.
`timescale 1ns/1ps
`include "fp_conv_cfg.svh"

module fp_unpack (
  input  logic                    clk,
  input  logic                    load_operand,
  input  fp_conv_pkg::fp_word_t   a_data,
  output fp_conv_pkg::fp_fields_t fields,
  output logic                    is_zero,
  output logic                    is_overflow
);

  import fp_conv_pkg::*;

  fp_word_t   operand_q;
  logic [7:0] exp_field;

  always_ff @(posedge clk) begin
    if (load_operand) begin
      operand_q <= a_data;
    end
  end

  assign exp_field = operand_q[`FP_MANT_BITS+7:`FP_MANT_BITS];

  always_comb begin
    fields.sign = operand_q[`FP_MANT_BITS+8];
    fields.exp  = exp_t'({1'b0, exp_field}) - exp_t'(`FP_EXP_BIAS);
    fields.mant = {1'b1, operand_q[`FP_MANT_BITS-1:0],
                   {(`INT_WIDTH-1-`FP_MANT_BITS){1'b0}}}; // hidden one restored.
  end

  // zero and subnormals alike.
  assign is_zero = (exp_field == 8'd0);

  // also catches inf and NaN as field 255 gives +128.
  assign is_overflow = (fields.exp > exp_t'(`SHIFT_STOP_EXP));

endmodule

//--- verilog/fp_conv_pkg.sv
// Types shared by the float to int converter blocks.
// Word widths come from the format macros.
`include "fp_conv_cfg.svh"

package fp_conv_pkg;

  // raw binary32 word: sign, 8 bit exponent field, fraction.
  typedef logic [`FP_MANT_BITS+8:0] fp_word_t;

  typedef logic [`INT_WIDTH-1:0] int_word_t;

  // unbiased exponent, wide enough for -127 and +128.
  typedef logic signed [8:0] exp_t;

  // hidden one at the msb, fraction below it, zero padded.
  typedef logic [`INT_WIDTH-1:0] mant_t;

  typedef struct packed {
    logic  sign;
    exp_t  exp;
    mant_t mant;
  } fp_fields_t;

  typedef enum logic [2:0] {
    idle,
    classify,
    align,
    pack,
    emit
  } conv_state_t;

  typedef enum logic [1:0] {
    res_zero,
    res_sat,
    res_shifted
  } result_sel_t;

endpackage

//--- verilog/fp_conv_cfg.svh
// Single precision format constants for the float to int converter.
// Changing these does not retarget the datapath to another float format.
`ifndef FP_CONV_CFG_SVH
`define FP_CONV_CFG_SVH

// exponent bias of the binary32 format.
`define FP_EXP_BIAS 127

// stored fraction bits without the hidden one.
`define FP_MANT_BITS 23

// result width, two's complement.
`define INT_WIDTH 32

// result for |x| >= 2^31, infinities and NaNs.
`define INT_SAT_VALUE 32'h8000_0000

// alignment stops once the unbiased exponent reaches this.
`define SHIFT_STOP_EXP 31

`endif
